/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////

// Machine word, also the PC width
`define DATA_WIDTH 16

// Architectural register count, R0 hardwired to zero
`define REG_COUNT 16

// Enough bits to name every register
`define REG_ID_WIDTH 4

`endif

/* isaPkg.sv */
package isaPkg;

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    ADD    = 4'd0,  // Rd = Rs + Rt, saturating
    SUB    = 4'd1,
    XOR    = 4'd2,
    RED    = 4'd3,  // Reduction add
    SLL    = 4'd4,  // Shifts take imm4 as the amount
    SRA    = 4'd5,
    ROR    = 4'd6,
    PADDSB = 4'd7,  // Nibble-wise saturating add
    LW     = 4'd8,  // Address is Rs + signed imm4 * 2
    SW     = 4'd9,
    LLB    = 4'd10, // Load low byte of Rd
    LHB    = 4'd11, // Load high byte of Rd
    B      = 4'd12, // PC relative branch
    BR     = 4'd13, // Branch to register
    PCS    = 4'd14, // Rd = PC + 2
    HLT    = 4'd15
  } opcodeT;

  // Branch condition codes, bits 11:9 of B and BR
  typedef enum logic [2:0] {
    NEQ    = 3'd0,
    EQ     = 3'd1,
    GT     = 3'd2,
    LT     = 3'd3,
    GTE    = 3'd4,
    LTE    = 3'd5,
    OVFL   = 3'd6,
    UNCOND = 3'd7
  } condT;

  ////////////////////////////////////////
  // Instruction field positions
  ////////////////////////////////////////
  localparam int OP_HI   = 15; // Opcode
  localparam int OP_LO   = 12;
  localparam int RD_HI   = 11; // Destination
  localparam int RD_LO   = 8;
  localparam int RS_HI   = 7;  // First source
  localparam int RS_LO   = 4;
  localparam int RT_HI   = 3;  // Second source
  localparam int RT_LO   = 0;
  localparam int IMM4_HI = 3;  // Shift amount or memory offset
  localparam int IMM4_LO = 0;
  localparam int IMM8_HI = 7;  // Byte for LLB and LHB
  localparam int IMM8_LO = 0;
  localparam int COND_HI = 11; // Branch condition
  localparam int COND_LO = 9;
  localparam int IMM9_HI = 8;  // Branch offset in halfwords
  localparam int IMM9_LO = 0;
  localparam int BR_BIT  = 12; // Low opcode bit splits BR from B

endpackage

/* pipePkg.sv */
`include "cpu_config.svh"

package pipePkg;

  // Basic datapath types
  typedef logic [`DATA_WIDTH-1:0]   wordT;
  typedef logic [`REG_ID_WIDTH-1:0] regIdT;

  // Flag register as kept by execute, Z in the top bit
  typedef struct packed {
    logic z; // Zero
    logic v; // Overflow
    logic n; // Negative
  } flagsT;

  ////////////////////////////////////////
  // Per-stage bundles
  ////////////////////////////////////////

  // Consumed by execute
  typedef struct packed {
    regIdT          srcReg1; // Ids kept for forwarding
    regIdT          srcReg2;
    wordT           aluIn1;
    wordT           aluImm;
    wordT           aluIn2;
    isaPkg::opcodeT aluOp;
    logic           aluSrc;  // Immediate on port 2
    logic           zEn;     // Update Z
    logic           nvEn;    // Update N and V
  } exBundleT;

  // Consumed by memory
  typedef struct packed {
    wordT memWriteData; // Store data
    logic memEnable;
    logic memWrite;
  } memBundleT;

  // Consumed by write-back
  typedef struct packed {
    regIdT regRd;
    logic  regWrite;
    logic  memToReg; // Load data instead of ALU result
    logic  hlt;
    logic  pcs;
  } wbBundleT;

endpackage

/* decodeIfs.sv */
// Register file read ports, two ids out and two words back
interface regReadIf;
  import pipePkg::*;

  regIdT srcReg1;
  regIdT srcReg2;
  wordT  srcData1;
  wordT  srcData2;

  modport requester (output srcReg1, srcReg2, input srcData1, srcData2);
  modport file      (input srcReg1, srcReg2, output srcData1, srcData2);
  modport observer  (input srcData1); // BR target tap
endinterface

// Decoded controls from the opcode decoder
interface controlIf;
  import isaPkg::*;

  opcodeT aluOp;
  logic   aluSrc;    // ALU port 2 takes the immediate
  logic   regSrc;    // Rd is read as a source, LLB and LHB
  logic   zEn;
  logic   nvEn;
  logic   memEnable;
  logic   memWrite;
  logic   regWrite;
  logic   memToReg;
  logic   hlt;
  logic   pcs;

  modport driver (output aluOp, aluSrc, regSrc, zEn, nvEn, memEnable, memWrite,
                  regWrite, memToReg, hlt, pcs);
  modport sink   (input aluOp, aluSrc, regSrc, zEn, nvEn, memEnable, memWrite,
                  regWrite, memToReg, hlt, pcs);
endinterface

/* controlUnit.sv */
module controlUnit (
  input  isaPkg::opcodeT opcode,          // Bits 15:12 of the current word
  input  logic           actualTaken,     // Resolved condition
  input  logic           predictedTaken,  // Direction guessed at fetch
  input  pipePkg::wordT  predictedTarget, // Target guessed at fetch
  input  pipePkg::wordT  branchTarget,    // Target computed here
  controlIf.driver       ctrl,
  output logic           isBranch,
  output logic           wenBtb,          // Refresh target buffer entry
  output logic           wenBht,          // Refresh history entry
  output logic           updatePc         // Redirect fetch
);
  import isaPkg::*;

  logic dirMiss;    // Direction guessed wrong
  logic targetMiss; // Taken, but fetch went elsewhere

  ////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////
  always_comb begin
    // Defaults cover B, BR and the idle cases
    ctrl.aluOp     = opcode; // ALU opcodes map one to one
    ctrl.aluSrc    = 1'b0;
    ctrl.regSrc    = 1'b0;
    ctrl.zEn       = 1'b0;
    ctrl.nvEn      = 1'b0;
    ctrl.memEnable = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.memToReg  = 1'b0;
    ctrl.hlt       = 1'b0;
    ctrl.pcs       = 1'b0;
    case (opcode)
      ADD, SUB: begin
        ctrl.zEn      = 1'b1;
        ctrl.nvEn     = 1'b1; // Only arithmetic can overflow
        ctrl.regWrite = 1'b1;
      end
      XOR: begin
        ctrl.zEn      = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      RED, PADDSB: ctrl.regWrite = 1'b1; // Flags untouched
      SLL, SRA, ROR: begin
        ctrl.aluSrc   = 1'b1; // Shift amount from imm4
        ctrl.zEn      = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      LW: begin
        ctrl.aluOp     = ADD; // Address add
        ctrl.aluSrc    = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.memToReg  = 1'b1;
      end
      SW: begin
        ctrl.aluOp     = ADD;
        ctrl.aluSrc    = 1'b1;
        ctrl.memEnable = 1'b1;
        ctrl.memWrite  = 1'b1;
      end
      LLB, LHB: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.regSrc   = 1'b1; // Merge into old Rd value
        ctrl.regWrite = 1'b1;
      end
      PCS: begin
        ctrl.regWrite = 1'b1;
        ctrl.pcs      = 1'b1;
      end
      HLT:     ctrl.hlt = 1'b1;
      default: ; // B and BR keep defaults
    endcase
  end

  ////////////////////////////////////////
  // Predictor update
  ////////////////////////////////////////
  assign isBranch   = (opcode == B) || (opcode == BR);
  assign dirMiss    = actualTaken != predictedTaken;
  assign targetMiss = !predictedTaken || (predictedTarget != branchTarget);

  assign wenBht   = isBranch && dirMiss;
  assign wenBtb   = isBranch && actualTaken && targetMiss;
  assign updatePc = wenBht || wenBtb; // Any miss flushes fetch
endmodule

/* branchControl.sv */
`include "cpu_config.svh"

module branchControl (
  input  pipePkg::wordT  pcInst,      // Current instruction word
  input  pipePkg::wordT  pcNext,      // Address after this word
  input  pipePkg::flagsT flags,
  regReadIf.observer     rd,          // Rs data for BR
  output logic           isBr,        // Register form of branch
  output logic           actualTaken, // Condition holds
  output pipePkg::wordT  branchTarget
);
  import isaPkg::*;
  import pipePkg::*;

  condT       cond;
  logic [8:0] imm9;      // Signed halfword offset
  wordT       offset;    // Byte offset

  assign cond = condT'(pcInst[COND_HI:COND_LO]);
  assign imm9 = pcInst[IMM9_HI:IMM9_LO];
  assign isBr = pcInst[BR_BIT];

  ////////////////////////////////////////
  // Condition evaluation
  ////////////////////////////////////////
  always_comb begin
    case (cond)
      NEQ:     actualTaken = !flags.z;
      EQ:      actualTaken = flags.z;
      GT:      actualTaken = !flags.z && !flags.n; // Strictly positive
      LT:      actualTaken = flags.n;
      GTE:     actualTaken = flags.z || !flags.n;
      LTE:     actualTaken = flags.z || flags.n;
      OVFL:    actualTaken = flags.v;
      UNCOND:  actualTaken = 1'b1;
      default: actualTaken = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Target
  ////////////////////////////////////////

  // Sign extend then scale to bytes
  assign offset = {{(`DATA_WIDTH-10){imm9[8]}}, imm9, 1'b0};

  // BR jumps to Rs, B is PC relative from the next word
  assign branchTarget = isBr ? rd.srcData1 : pcNext + offset;
endmodule

/* registerFile.sv */
`include "cpu_config.svh"

module registerFile (
  input  logic          clk,
  input  logic          reset,       // Clears every register
  input  logic          writeEnable, // From write-back
  input  pipePkg::regIdT writeId,
  input  pipePkg::wordT  writeData,
  regReadIf.file        rd
);
  import pipePkg::*;

  wordT regs [`REG_COUNT]; // Architectural state
  logic hit1;              // Write-back targets read port 1
  logic hit2;

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (writeEnable && (writeId != '0)) begin
      regs[writeId] <= writeData; // R0 never written
    end
  end

  ////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////

  // Same cycle write is passed straight through
  assign hit1 = writeEnable && (writeId == rd.srcReg1);
  assign hit2 = writeEnable && (writeId == rd.srcReg2);

  // R0 check first so a write to R0 cannot leak through the bypass
  assign rd.srcData1 = (rd.srcReg1 == '0) ? '0 :
                       hit1               ? writeData :
                                            regs[rd.srcReg1];
  assign rd.srcData2 = (rd.srcReg2 == '0) ? '0 :
                       hit2               ? writeData :
                                            regs[rd.srcReg2];
endmodule

/* operandSelect.sv */
`include "cpu_config.svh"

module operandSelect (
  input  pipePkg::wordT      pcInst,
  controlIf.sink             ctrl,
  regReadIf.requester        rd,
  output pipePkg::exBundleT  exSignals,
  output pipePkg::memBundleT memSignals,
  output pipePkg::wbBundleT  wbSignals
);
  import isaPkg::*;
  import pipePkg::*;

  regIdT      rdId;   // Destination field
  regIdT      rsId;
  regIdT      rtId;
  logic [3:0] imm4;
  logic [7:0] imm8;   // Byte for LLB and LHB
  wordT       immExt; // imm4 after extension
  wordT       aluImm;

  assign rdId = pcInst[RD_HI:RD_LO];
  assign rsId = pcInst[RS_HI:RS_LO];
  assign rtId = pcInst[RT_HI:RT_LO];
  assign imm4 = pcInst[IMM4_HI:IMM4_LO];
  assign imm8 = pcInst[IMM8_HI:IMM8_LO];

  ////////////////////////////////////////
  // Register ids and immediates
  ////////////////////////////////////////
  assign rd.srcReg1 = ctrl.regSrc   ? rdId : rsId; // LLB/LHB read old Rd
  assign rd.srcReg2 = ctrl.memWrite ? rdId : rtId; // SW stores Rd

  // Memory offsets are signed, shift amounts are not
  assign immExt = ctrl.memEnable ? {{(`DATA_WIDTH-4){imm4[3]}}, imm4}
                                 : {{(`DATA_WIDTH-4){1'b0}}, imm4};
  assign aluImm = ctrl.regSrc ? {{(`DATA_WIDTH-8){1'b0}}, imm8} : immExt;

  ////////////////////////////////////////
  // Bundle packing
  ////////////////////////////////////////
  always_comb begin
    exSignals.srcReg1 = rd.srcReg1;
    exSignals.srcReg2 = rd.srcReg2;
    exSignals.aluIn1  = rd.srcData1;
    exSignals.aluImm  = aluImm;
    exSignals.aluIn2  = ctrl.aluSrc ? aluImm : rd.srcData2;
    exSignals.aluOp   = ctrl.aluOp;
    exSignals.aluSrc  = ctrl.aluSrc;
    exSignals.zEn     = ctrl.zEn;
    exSignals.nvEn    = ctrl.nvEn;

    memSignals.memWriteData = rd.srcData2; // Rd data on SW
    memSignals.memEnable    = ctrl.memEnable;
    memSignals.memWrite     = ctrl.memWrite;

    wbSignals.regRd    = rdId;
    wbSignals.regWrite = ctrl.regWrite;
    wbSignals.memToReg = ctrl.memToReg;
    wbSignals.hlt      = ctrl.hlt;
    wbSignals.pcs      = ctrl.pcs;
  end
endmodule

/* decodeStage.sv */
module decodeStage (
  input  logic               clk,
  input  logic               reset,
  input  pipePkg::wordT      pcInst,          // Word from IF/ID
  input  pipePkg::wordT      pcNext,          // PC + 2 from IF/ID
  input  pipePkg::flagsT     flags,           // Current Z, V, N
  input  logic               predictedTaken,
  input  pipePkg::wordT      predictedTarget,
  input  logic               wbRegWrite,      // Write port from MEM/WB
  input  pipePkg::regIdT     wbRegRd,
  input  pipePkg::wordT      wbData,
  output pipePkg::exBundleT  exSignals,
  output pipePkg::memBundleT memSignals,
  output pipePkg::wbBundleT  wbSignals,
  output logic               isBranch,
  output logic               isBr,
  output pipePkg::wordT      branchTarget,
  output logic               actualTaken,
  output logic               wenBtb,
  output logic               wenBht,
  output logic               updatePc
);
  import isaPkg::*;

  opcodeT opcode;

  regReadIf rdBus ();  // Operand ids out, register data back
  controlIf ctrlBus (); // Decoded controls

  assign opcode = opcodeT'(pcInst[OP_HI:OP_LO]);

  controlUnit uCtrl (
    .opcode          (opcode),
    .actualTaken     (actualTaken),
    .predictedTaken  (predictedTaken),
    .predictedTarget (predictedTarget),
    .branchTarget    (branchTarget),
    .ctrl            (ctrlBus.driver),
    .isBranch        (isBranch),
    .wenBtb          (wenBtb),
    .wenBht          (wenBht),
    .updatePc        (updatePc)
  );

  branchControl uBranch (
    .pcInst       (pcInst),
    .pcNext       (pcNext),
    .flags        (flags),
    .rd           (rdBus.observer),
    .isBr         (isBr),
    .actualTaken  (actualTaken),
    .branchTarget (branchTarget)
  );

  registerFile uRegs (
    .clk         (clk),
    .reset       (reset),
    .writeEnable (wbRegWrite),
    .writeId     (wbRegRd),
    .writeData   (wbData),
    .rd          (rdBus.file)
  );

  operandSelect uOperands (
    .pcInst     (pcInst),
    .ctrl       (ctrlBus.sink),
    .rd         (rdBus.requester),
    .exSignals  (exSignals),
    .memSignals (memSignals),
    .wbSignals  (wbSignals)
  );
endmodule

/* tb_clock.sv */
module tb_clock (
  output logic clk,
  output logic reset
);
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 unit period
  end

  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #2 reset = 1'b0; // Released with the other inputs
  end
endmodule

/* decode_tb.sv */
`include "cpu_config.svh"

module decode_tb;
  import isaPkg::*;
  import pipePkg::*;

  localparam int MAX_CYCLES = 400; // Tests take about 210

  logic      clk, reset;
  wordT      pcInst, pcNext, predictedTarget, wbData, branchTarget;
  flagsT     flags;
  logic      predictedTaken, wbRegWrite;
  regIdT     wbRegRd;
  exBundleT  exSignals;
  memBundleT memSignals;
  wbBundleT  wbSignals;
  logic      isBranch, isBr, actualTaken, wenBtb, wenBht, updatePc;

  logic [31:0] rngState;
  wordT        model [`REG_COUNT]; // Expected register contents

  tb_clock clkGen (.clk(clk), .reset(reset));
  decodeStage uut (.*);

  ////////////////////////////////////////
  // Random source and reference rules
  ////////////////////////////////////////
  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function logic [31:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic wordT encode(opcodeT op, logic [11:0] rest);
    return {op, rest};
  endfunction

  function automatic exBundleT refEx(wordT inst);
    opcodeT   op;
    exBundleT e;
    op        = opcodeT'(inst[15:12]);
    e.srcReg1 = (op inside {LLB, LHB}) ? inst[11:8] : inst[7:4]; // Byte loads merge into Rd
    e.srcReg2 = (op == SW) ? inst[11:8] : inst[3:0];
    if (op inside {LLB, LHB}) e.aluImm = {8'h00, inst[7:0]};
    else if (op inside {LW, SW}) e.aluImm = 16'($signed(inst[3:0])); // Signed offset
    else e.aluImm = {12'h000, inst[3:0]};
    e.aluSrc = op inside {SLL, SRA, ROR, LW, SW, LLB, LHB};
    e.aluIn1 = model[e.srcReg1];
    e.aluIn2 = e.aluSrc ? e.aluImm : model[e.srcReg2];
    e.aluOp  = (op inside {LW, SW}) ? ADD : op;
    e.zEn    = op inside {ADD, SUB, XOR, SLL, SRA, ROR};
    e.nvEn   = op inside {ADD, SUB};
    return e;
  endfunction

  function automatic memBundleT refMem(wordT inst);
    exBundleT  e;
    memBundleT m;
    e              = refEx(inst);
    m.memWriteData = model[e.srcReg2]; // Store data is the second read
    m.memEnable    = inst[15:12] inside {LW, SW};
    m.memWrite     = inst[15:12] == SW;
    return m;
  endfunction

  function automatic wbBundleT refWb(wordT inst);
    wbBundleT w;
    w.regRd    = inst[11:8];
    w.regWrite = (inst[15:12] <= 4'd8) || (inst[15:12] inside {LLB, LHB, PCS});
    w.memToReg = inst[15:12] == LW;
    w.hlt      = inst[15:12] == HLT;
    w.pcs      = inst[15:12] == PCS;
    return w;
  endfunction

  function automatic logic refTaken(condT c, flagsT f);
    case (c)
      NEQ:     return !f.z;
      EQ:      return f.z;
      GT:      return !(f.z || f.n);
      LT:      return f.n;
      GTE:     return f.z || !f.n;
      LTE:     return f.z || f.n;
      OVFL:    return f.v;
      default: return 1'b1; // UNCOND
    endcase
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic reportMismatch(string name, logic [63:0] exp, logic [63:0] act);
    $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, exp, act);
    $display("** FAIL **");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic checkEx(string name, exBundleT exp, exBundleT act);
    if (act !== exp) reportMismatch(name, exp, act);
  endtask

  task automatic checkMem(string name, memBundleT exp, memBundleT act);
    if (act !== exp) reportMismatch(name, exp, act);
  endtask

  task automatic checkWb(string name, wbBundleT exp, wbBundleT act);
    if (act !== exp) reportMismatch(name, exp, act);
  endtask

  task automatic checkData(string name, wordT exp, wordT act);
    if (act !== exp) reportMismatch(name, exp, act);
  endtask

  task automatic checkBit(string name, logic exp, logic act);
    if (act !== exp) reportMismatch(name, exp, act);
  endtask

  ////////////////////////////////////////
  // Drive and decode check
  ////////////////////////////////////////
  task automatic applyInputs(wordT inst, wordT next, flagsT f, logic pt, wordT ptgt,
                             logic we, regIdT wid, wordT wdata);
    @(posedge clk);
    #2;
    pcInst          = inst;
    pcNext          = next;
    flags           = f;
    predictedTaken  = pt;
    predictedTarget = ptgt;
    wbRegWrite      = we;
    wbRegRd         = wid;
    wbData          = wdata;
    #15;                                   // Settled just before the next edge
    if (we && wid != '0) model[wid] = wdata; // Bypass makes it visible already
  endtask

  task automatic drive(wordT inst); // Plain word without write-back
    applyInputs(inst, 16'h0200, '0, 1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic verifyDecode();
    checkEx("exSignals", refEx(pcInst), exSignals);
    checkMem("memSignals", refMem(pcInst), memSignals);
    checkWb("wbSignals", refWb(pcInst), wbSignals);
    if (pcInst[15:13] != 3'b110) begin     // Neither B nor BR
      checkBit("isBranch", 1'b0, isBranch);
      checkBit("wenBtb", 1'b0, wenBtb);
      checkBit("wenBht", 1'b0, wenBht);
      checkBit("updatePc", 1'b0, updatePc);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////
  task automatic readAll(); // Every id on both ports
    for (int i = 0; i < `REG_COUNT; i++) begin
      drive(encode(ADD, {4'h0, 4'(i), 4'(15 - i)}));
      verifyDecode();
    end
  endtask

  task automatic testRegisters();
    regIdT id;
    wordT  data;
    readAll();                             // All zero after reset
    for (int i = 0; i < 20; i++) begin
      id   = regIdT'(nextRand() % 15 + 1);
      data = wordT'(nextRand());
      applyInputs(encode(ADD, {4'h1, id, 4'(i)}), 16'h0200, '0, 1'b0, '0, 1'b1, id, data);
      verifyDecode();                      // Rs equals the write id
    end
    applyInputs(encode(ADD, 12'h000), 16'h0200, '0, 1'b0, '0, 1'b1, 4'h0, 16'hbeef);
    verifyDecode();                        // R0 ignores writes even when bypassed
    readAll();
  endtask

  task automatic testAluAndImm();
    opcodeT immOps [7] = '{SLL, SRA, ROR, LW, SW, LLB, LHB};
    logic [11:0] rest;
    for (int op = 0; op < 8; op++)
      for (int k = 0; k < 4; k++) begin
        drive(encode(opcodeT'(op), 12'(nextRand())));
        verifyDecode();
      end
    foreach (immOps[j])
      for (int k = 0; k < 6; k++) begin
        rest = 12'(nextRand());
        if (k < 2) rest[3] = k[0];         // Both imm4 signs at least once
        drive(encode(immOps[j], rest));
        verifyDecode();
      end
  endtask

  task automatic testConditions();
    logic [31:0] r;
    flagsT       f;
    for (int c = 0; c < 8; c++)
      for (int k = 0; k < 8; k++) begin
        r = nextRand();
        f = r[2:0];
        applyInputs(encode(B, {3'(c), r[16:8]}), 16'h0200, f, 1'b0, '0, 1'b0, '0, '0);
        checkBit("actualTaken", refTaken(condT'(c), f), actualTaken);
        checkBit("isBranch", 1'b1, isBranch);
      end
  endtask

  task automatic testTargets();
    logic [8:0] offs [3] = '{9'h023, 9'h1f0, 9'h100}; // Up, down, furthest down
    wordT       next;
    regIdT      id;
    condT       cond;
    logic       btb;
    foreach (offs[i]) begin
      next = wordT'(nextRand()) & 16'hfffe;
      applyInputs(encode(B, {UNCOND, offs[i]}), next, '0, 1'b0, '0, 1'b0, '0, '0);
      checkData("branchTarget", next + 16'(2 * $signed(offs[i])), branchTarget);
      checkBit("isBr", 1'b0, isBr);
    end
    for (int i = 0; i < 3; i++) begin
      id = regIdT'(nextRand() % 15 + 1);
      drive(encode(BR, {UNCOND, 1'b0, id, 4'h0}));
      verifyDecode();
      checkData("branchTarget", model[id], branchTarget); // Rs data
      checkBit("isBr", 1'b1, isBr);
      checkBit("isBranch", 1'b1, isBranch);
    end
    // Taken or not, predicted or not, target guess right or wrong
    for (int t = 0; t < 2; t++)
      for (int p = 0; p < 2; p++)
        for (int m = 0; m < 2; m++) begin
          cond = t[0] ? UNCOND : EQ;       // EQ with z clear falls through
          applyInputs(encode(B, {cond, 9'h020}), 16'h0300, '0, p[0],
                      m[0] ? 16'h0350 : 16'h0340, 1'b0, '0, '0);
          btb = t[0] && (!p[0] || m[0]);
          checkData("branchTarget", 16'h0340, branchTarget);
          checkBit("wenBht", t[0] != p[0], wenBht);
          checkBit("wenBtb", btb, wenBtb);
          checkBit("updatePc", btb || (t[0] != p[0]), updatePc);
        end
  endtask

  task automatic testSpecials();
    drive(encode(HLT, 12'(nextRand())));
    verifyDecode();
    checkBit("wbSignals.hlt", 1'b1, wbSignals.hlt);
    drive(encode(PCS, 12'(nextRand())));
    verifyDecode();
    checkBit("wbSignals.regWrite", 1'b1, wbSignals.regWrite);
  endtask

  initial begin
    rngState        = 32'hd6042d8c;
    pcInst          = '0;              // ADD R0, R0, R0 while in reset
    pcNext          = '0;
    flags           = '0;
    predictedTaken  = 1'b0;
    predictedTarget = '0;
    wbRegWrite      = 1'b0;
    wbRegRd         = '0;
    wbData          = '0;
    foreach (model[i]) model[i] = '0;
    @(negedge reset);
    testRegisters();
    testAluAndImm();
    testConditions();
    testTargets();
    testSpecials();
    $display("** PASS **");
    $finish;
  end

  initial begin // Watchdog
    #(MAX_CYCLES * 20);
    $display("simulation timed out");
    $display("** FAIL **");
    $fatal(1, "watchdog expired");
  end
endmodule

/* compile.f */
+incdir+.
isaPkg.sv
pipePkg.sv
decodeIfs.sv
controlUnit.sv
branchControl.sv
registerFile.sv
operandSelect.sv
decodeStage.sv
tb_clock.sv
decode_tb.sv
